// File: hw/bus_pkg.sv
package bus_pkg;

	// bus widths
	typedef logic [15:0] addr_t; // 6502 address space
	typedef logic [7:0]  data_t; // one bus byte

	// low system ram
	localparam addr_t RAM_BASE = 16'h0000;
	localparam addr_t RAM_LAST = 16'h3FFF;

	// ram that holds integer basic once loaded
	localparam addr_t BASIC_BASE = 16'hE000;
	localparam addr_t BASIC_LAST = 16'hEFFF;

	// cassette interface card window
	localparam addr_t ACI_BASE = 16'hC000;
	localparam addr_t ACI_LAST = 16'hC1FF;

	// woz monitor page, runs to the top of memory
	localparam addr_t ROM_BASE = 16'hFF00;

	// array depths, must match the windows above
	localparam int RAM_WORDS   = 16384;
	localparam int BASIC_WORDS = 4096;
	localparam int ROM_WORDS   = 256;

	// monitor image, path as seen from the sim run directory
	localparam string ROM_FILE = "hw/rom_wozmon.hex";

endpackage

// File: hw/timing_pkg.sv
package timing_pkg;

	// sys clock is cpu x 7 x 8
	localparam int CPU_CLKEN_DIV = 56;

	typedef logic [$clog2(CPU_CLKEN_DIV)-1:0] clken_count_t; // counts 0 .. div-1

	// tape monitor dac
	localparam int DAC_BITS = 16;

	typedef logic [DAC_BITS-1:0] dac_sample_t; // unsigned sample, also the accumulator

endpackage

// File: hw/mem_bus_if.sv
interface mem_bus_if;

	// registered request, valid only in the cycle wr or rd is high
	bus_pkg::addr_t addr;
	bus_pkg::data_t wdata;
	logic           wr;    // write strobe
	logic           rd;    // read strobe

	// arbiter side
	modport producer (
		output addr,
		output wdata,
		output wr,
		output rd
	);

	// memory side, always accepts
	modport bank (
		input addr,
		input wdata,
		input wr,
		input rd
	);

endinterface

// File: hw/clock_enable_gen.sv
module clock_enable_gen (
	input  logic sys_clock,
	input  logic reset_i,
	output logic cpu_clken_o
);
	import timing_pkg::*;

	clken_count_t div_count;
	logic         div_wrap;

	// last count of the period
	assign div_wrap = (div_count == clken_count_t'(CPU_CLKEN_DIV - 1));

	always_ff @(posedge sys_clock) begin
		if (reset_i) begin
			div_count   <= '0;
			cpu_clken_o <= 1'b0;
		end else begin
			if (div_wrap) begin
				div_count <= '0; // restart period
			end else begin
				div_count <= div_count + clken_count_t'(1);
			end
			cpu_clken_o <= div_wrap; // one cycle wide once per period
		end
	end

endmodule

// File: hw/bus_arbiter.sv
module bus_arbiter (
	input  logic           sys_clock,
	input  logic           reset_i,
	input  logic           cpu_clken_i,
	input  bus_pkg::addr_t cpu_addr_i,
	input  bus_pkg::data_t cpu_wdata_i,
	input  logic           cpu_wr_i,
	input  logic           cpu_rd_i,
	input  logic           dl_active_i,
	input  logic           dl_wr_i,
	input  bus_pkg::addr_t dl_addr_i,
	input  bus_pkg::data_t dl_data_i,
	mem_bus_if.producer    bus,
	output logic           cpu_clken_o,
	output logic           led_o
);
	import bus_pkg::*;

	logic  dl_write;
	addr_t sel_addr;
	data_t sel_wdata;
	logic  sel_wr;
	logic  sel_rd;

	assign dl_write = dl_active_i & dl_wr_i;

	// loader write beats the cpu in the same cycle
	always_comb begin
		if (dl_write) begin
			sel_addr  = dl_addr_i;
			sel_wdata = dl_data_i;
			sel_wr    = 1'b1;
			sel_rd    = 1'b0; // loader never reads
		end else begin
			sel_addr  = cpu_addr_i;
			sel_wdata = cpu_wdata_i;
			sel_wr    = cpu_wr_i;
			sel_rd    = cpu_rd_i;
		end
	end

	// address and data payload
	always_ff @(posedge sys_clock) begin
		bus.addr  <= sel_addr;
		bus.wdata <= sel_wdata;
	end

	// strobes
	always_ff @(posedge sys_clock) begin
		if (reset_i) begin
			bus.wr <= 1'b0;
			bus.rd <= 1'b0;
		end else begin
			bus.wr <= sel_wr;
			bus.rd <= sel_rd;
		end
	end

	assign cpu_clken_o = cpu_clken_i & ~dl_active_i; // cpu frozen during download
	assign led_o       = ~dl_write;                  // active low activity led

endmodule

// File: hw/memory_banks.sv
module memory_banks (
	input  logic           sys_clock,
	input  logic           reset_i,
	mem_bus_if.bank        bus,
	input  logic           tape_in_i,
	output bus_pkg::data_t rdata_o,
	output logic           aci_access_o
);
	import bus_pkg::*;

	typedef logic [$clog2(RAM_WORDS)-1:0]   ram_idx_t;
	typedef logic [$clog2(BASIC_WORDS)-1:0] basic_idx_t;
	typedef logic [$clog2(ROM_WORDS)-1:0]   rom_idx_t;

	data_t ram_mem   [RAM_WORDS];
	data_t basic_mem [BASIC_WORDS];
	data_t rom_mem   [ROM_WORDS];

	logic       ram_cs;
	logic       basic_cs;
	logic       aci_cs;
	logic       rom_cs;
	ram_idx_t   ram_idx;
	basic_idx_t basic_idx;
	rom_idx_t   rom_idx;
	data_t      rd_sel;

	// monitor image, read only from here on
	initial begin
		$readmemh(ROM_FILE, rom_mem);
	end

	// chip selects from the registered address
	assign ram_cs   = (bus.addr <= RAM_LAST);                            // 0000-3fff
	assign basic_cs = (bus.addr >= BASIC_BASE) && (bus.addr <= BASIC_LAST); // e000-efff
	assign aci_cs   = (bus.addr >= ACI_BASE) && (bus.addr <= ACI_LAST);     // c000-c1ff
	assign rom_cs   = (bus.addr >= ROM_BASE);                            // ff00-ffff
	// 4000-bfff and the gaps fall through to zero

	// offsets into each array
	assign ram_idx   = ram_idx_t'(bus.addr - RAM_BASE);
	assign basic_idx = basic_idx_t'(bus.addr - BASIC_BASE);
	assign rom_idx   = rom_idx_t'(bus.addr - ROM_BASE);

	always_ff @(posedge sys_clock) begin
		if (bus.wr && ram_cs) begin
			ram_mem[ram_idx] <= bus.wdata;
		end
		if (bus.wr && basic_cs) begin
			basic_mem[basic_idx] <= bus.wdata;
		end
		// writes to rom are dropped
	end

	// fixed priority read mux
	always_comb begin
		if (rom_cs) begin
			rd_sel = rom_mem[rom_idx];
		end else if (basic_cs) begin
			rd_sel = basic_mem[basic_idx];
		end else if (aci_cs) begin
			rd_sel = data_t'(tape_in_i); // tape bit in d0, rest zero
		end else if (ram_cs) begin
			rd_sel = ram_mem[ram_idx];
		end else begin
			rd_sel = '0; // unmapped
		end
	end

	// second pipeline stage, read data valid after this edge
	always_ff @(posedge sys_clock) begin
		if (reset_i) begin
			rdata_o <= '0;
		end else if (bus.rd) begin
			rdata_o <= rd_sel;
		end
	end

	// any touch of the aci window, read or write
	assign aci_access_o = aci_cs & (bus.wr | bus.rd);

endmodule

// File: hw/tape_interface.sv
module tape_interface (
	input  logic sys_clock,
	input  logic reset_i,
	input  logic uart_rx_i,         // board audio input shares the uart pin
	input  logic monitor_tape_in_i, // 1 listens to tape in, 0 to tape out
	input  logic aci_access_i,
	output logic tape_in_o,
	output logic tape_out_o,
	output logic audio_l_o,
	output logic audio_r_o
);
	import timing_pkg::*;

	logic              monitor_bit;
	dac_sample_t       dac_sample;
	dac_sample_t       dac_acc;
	logic              dac_carry;
	logic [DAC_BITS:0] dac_sum;

	// cassette side
	always_ff @(posedge sys_clock) begin
		if (reset_i) begin
			tape_in_o  <= 1'b0;
			tape_out_o <= 1'b0;
		end else begin
			tape_in_o <= ~uart_rx_i; // input is inverted on the pin
			if (aci_access_i) begin
				tape_out_o <= ~tape_out_o; // every aci access flips the output
			end
		end
	end

	// what goes to the speaker
	assign monitor_bit = monitor_tape_in_i ? tape_in_o : tape_out_o;

	// full scale or silence
	assign dac_sample = {monitor_bit, {(DAC_BITS-1){1'b0}}};

	// first order delta sigma
	assign dac_sum = {1'b0, dac_acc} + {1'b0, dac_sample};

	always_ff @(posedge sys_clock) begin
		if (reset_i) begin
			dac_acc   <= '0;
			dac_carry <= 1'b0;
		end else begin
			dac_acc   <= dac_sum[DAC_BITS-1:0];
			dac_carry <= dac_sum[DAC_BITS]; // overflow is the 1 bit stream
		end
	end

	// same stream on both channels
	assign audio_l_o = dac_carry;
	assign audio_r_o = dac_carry;

endmodule

// File: hw/apple1_bus_top.sv
module apple1_bus_top (
	input  logic           sys_clock,
	input  logic           reset_i,
	input  bus_pkg::addr_t cpu_addr_i,
	input  bus_pkg::data_t cpu_wdata_i,
	input  logic           cpu_wr_i,
	input  logic           cpu_rd_i,
	input  logic           dl_active_i,  // download in progress
	input  logic           dl_wr_i,
	input  bus_pkg::addr_t dl_addr_i,
	input  bus_pkg::data_t dl_data_i,
	input  logic           uart_rx_i,
	input  logic           monitor_tape_in_i,
	output bus_pkg::data_t cpu_rdata_o,  // 2 cycles after the request
	output logic           cpu_clken_o,
	output logic           tape_out_o,
	output logic           audio_l_o,
	output logic           audio_r_o,
	output logic           led_o
);

	logic cpu_clken;  // free running, before download gating
	logic aci_access;
	logic tape_in;

	mem_bus_if bus0 ();

	clock_enable_gen clken_gen0 (
		.sys_clock   (sys_clock),
		.reset_i     (reset_i),
		.cpu_clken_o (cpu_clken)
	);

	// request source, first stage
	bus_arbiter arbiter0 (
		.sys_clock   (sys_clock),
		.reset_i     (reset_i),
		.cpu_clken_i (cpu_clken),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_wdata_i (cpu_wdata_i),
		.cpu_wr_i    (cpu_wr_i),
		.cpu_rd_i    (cpu_rd_i),
		.dl_active_i (dl_active_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.bus         (bus0.producer),
		.cpu_clken_o (cpu_clken_o),
		.led_o       (led_o)
	);

	// decode, arrays and read data, second stage
	memory_banks banks0 (
		.sys_clock    (sys_clock),
		.reset_i      (reset_i),
		.bus          (bus0.bank),
		.tape_in_i    (tape_in),
		.rdata_o      (cpu_rdata_o),
		.aci_access_o (aci_access)
	);

	tape_interface tape0 (
		.sys_clock         (sys_clock),
		.reset_i           (reset_i),
		.uart_rx_i         (uart_rx_i),
		.monitor_tape_in_i (monitor_tape_in_i),
		.aci_access_i      (aci_access),
		.tape_in_o         (tape_in),
		.tape_out_o        (tape_out_o),
		.audio_l_o         (audio_l_o),
		.audio_r_o         (audio_r_o)
	);

endmodule

// File: verification/apple1_bus_properties.sv
module apple1_bus_properties (
	input logic sys_clock,
	input logic reset_i,
	input logic dl_active_i,
	input logic cpu_clken_o,
	input logic audio_l_o,
	input logic audio_r_o
);

	// cpu frozen while the loader owns the bus
	clken_gated_in_download: assert property (@(posedge sys_clock) disable iff (reset_i)
		dl_active_i |-> !cpu_clken_o)
		else $error("cpu_clken_o high while dl_active_i is high");

	// both channels come from one flop
	audio_channels_equal: assert property (@(posedge sys_clock) disable iff (reset_i)
		audio_l_o == audio_r_o)
		else $error("audio_l_o and audio_r_o differ");

	clken_single_cycle: assert property (@(posedge sys_clock) disable iff (reset_i)
		cpu_clken_o |=> !cpu_clken_o)  // pulse is one cycle wide
		else $error("cpu_clken_o high on two consecutive cycles");

endmodule

// watch the top level ports
bind apple1_bus_top apple1_bus_properties props0 (
	.sys_clock   (sys_clock),
	.reset_i     (reset_i),
	.dl_active_i (dl_active_i),
	.cpu_clken_o (cpu_clken_o),
	.audio_l_o   (audio_l_o),
	.audio_r_o   (audio_r_o)
);

// File: verification/tb_apple1_bus.sv
module tb_apple1_bus;
	import bus_pkg::*;
	import timing_pkg::*;

	typedef enum logic [1:0] {OP_DL_WR, OP_CPU_WR, OP_CPU_RD} op_t;
	typedef struct packed {
		op_t   op;
		addr_t addr;
		data_t data;
		data_t exp_data; // only meaningful for reads
	} entry_t;

	localparam string ROM_PATH = "hw/rom_wozmon.hex";
	localparam int WATCHDOG_CYCLES = 20000;
	localparam addr_t MEM_ADDRS [6] = '{16'h0000, 16'h0001, 16'h1234, 16'h3FFF, 16'hE000, 16'hEFFF};
	localparam addr_t DEAD_ADDRS [5] = '{16'h4000, 16'h7FFF, 16'h8123, 16'hBFFF, 16'hF000};

	logic sys_clock, reset_i, cpu_wr_i, cpu_rd_i, dl_active_i, dl_wr_i;
	logic uart_rx_i, monitor_tape_in_i;
	addr_t cpu_addr_i, dl_addr_i;
	data_t cpu_wdata_i, dl_data_i, cpu_rdata_o;
	logic cpu_clken_o, tape_out_o, audio_l_o, audio_r_o, led_o;

	int unsigned lcg_state = 32'hb0eb_8a07;
	int check_errors = 0;
	int timeout_errors = 0;
	data_t rom_image [ROM_WORDS];
	data_t shadow [addr_t];  // bytes written to ram and basic
	entry_t stim_q [$];

	apple1_bus_top dut0 (.*);

	always #5 sys_clock = ~sys_clock;

	function automatic data_t rand_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16]; // upper bits have the better randomness
	endfunction

	function automatic logic writable(addr_t a);
		return (a <= RAM_LAST) || (a >= BASIC_BASE && a <= BASIC_LAST);
	endfunction

	// expected read byte from the memory map
	function automatic data_t model_read(addr_t a);
		if (a >= ROM_BASE) return rom_image[8'(a - ROM_BASE)];
		if (writable(a)) return shadow.exists(a) ? shadow[a] : 8'h00;
		return 8'h00; // unmapped
	endfunction

	function automatic void add_entry(op_t op, addr_t a, data_t d);
		entry_t e;
		e = '{op: op, addr: a, data: d, exp_data: 8'h00};
		if (op != OP_CPU_RD && writable(a)) shadow[a] = d;
		if (op == OP_CPU_RD) e.exp_data = model_read(a);
		stim_q.push_back(e);
	endfunction

	task automatic check_data(string name, data_t got, data_t exp);
		if (got !== exp) begin
			check_errors++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			check_errors++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp) begin
			check_errors++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// one loader write that leaves dl_active_i at hold
	task automatic loader_write(addr_t a, data_t d, logic hold);
		@(posedge sys_clock);
		dl_active_i <= 1'b1;
		dl_wr_i     <= 1'b1;
		dl_addr_i   <= a;
		dl_data_i   <= d;
		@(negedge sys_clock);
		check_bit("led_o", led_o, 1'b0); // led on during the write
		@(posedge sys_clock);
		dl_wr_i     <= 1'b0;
		dl_active_i <= hold;
	endtask

	task automatic cpu_access(addr_t a, data_t d, logic wr, output data_t rd);
		@(posedge sys_clock);             // edge k presents the request
		cpu_addr_i  <= a;
		cpu_wdata_i <= d;
		cpu_wr_i    <= wr;
		cpu_rd_i    <= ~wr;
		@(posedge sys_clock);             // k+1 registered
		cpu_wr_i <= 1'b0;
		cpu_rd_i <= 1'b0;
		@(posedge sys_clock);             // k+2 data and tape flop
		@(negedge sys_clock);
		rd = cpu_rdata_o;
	endtask

	// bounded wait for the next enable pulse that returns the cycles waited
	task automatic wait_clken(output int cycles);
		int n;
		n = 0;
		do begin
			@(negedge sys_clock);
			n++;
		end while (!cpu_clken_o && n < 2 * CPU_CLKEN_DIV);
		if (!cpu_clken_o) begin
			timeout_errors++;
			$display("timeout: no cpu_clken_o pulse within %0d cycles", n);
		end
		cycles = n;
	endtask

	initial begin
		int pulses, n, high, high_r;
		data_t got, d;
		logic rx;
		{sys_clock, cpu_wr_i, cpu_rd_i, dl_active_i, dl_wr_i, monitor_tape_in_i} = '0;
		{cpu_addr_i, dl_addr_i, cpu_wdata_i, dl_data_i} = '0;
		uart_rx_i = 1'b1;  // line idle
		reset_i = 1'b1;
		$readmemh(ROM_PATH, rom_image);
		repeat (16) @(posedge sys_clock);
		reset_i <= 1'b0;

		// cpu enable must stay quiet through a download
		pulses = 0;
		for (int i = 0; i < 16; i++) begin
			loader_write(16'h0200 + addr_t'(i), rand_byte(), 1'b1);
			shadow[16'h0200 + addr_t'(i)] = dl_data_i;
			repeat (6) begin
				@(negedge sys_clock);
				pulses += int'(cpu_clken_o);
			end
		end
		check_count("cpu_clken_o pulses in download", pulses, 0);
		@(posedge sys_clock);
		dl_active_i <= 1'b0;
		wait_clken(n);
		for (int i = 0; i < 3; i++) begin
			wait_clken(n);
			check_count("cpu_clken_o period", n, CPU_CLKEN_DIV);
		end

		// table covers ram and basic then rom then unmapped
		foreach (MEM_ADDRS[i]) add_entry(OP_DL_WR, MEM_ADDRS[i], rand_byte());
		add_entry(OP_CPU_WR, 16'h2000, rand_byte());
		add_entry(OP_DL_WR, 16'hE800, rand_byte());
		add_entry(OP_CPU_WR, 16'hE800, rand_byte()); // overwrite
		foreach (MEM_ADDRS[i]) add_entry(OP_CPU_RD, MEM_ADDRS[i], 8'h00);
		add_entry(OP_CPU_RD, 16'h2000, 8'h00);
		add_entry(OP_CPU_RD, 16'hE800, 8'h00);
		for (int i = 0; i < 16; i++) add_entry(OP_CPU_RD, 16'h0200 + addr_t'(i), 8'h00);
		add_entry(OP_CPU_WR, 16'hFF10, rand_byte());
		add_entry(OP_DL_WR, 16'hFFFC, rand_byte());
		add_entry(OP_CPU_RD, 16'hFF00, 8'h00);
		add_entry(OP_CPU_RD, 16'hFF10, 8'h00);
		add_entry(OP_CPU_RD, 16'hFFFC, 8'h00);
		add_entry(OP_CPU_RD, 16'hFFFF, 8'h00);
		for (int i = 0; i < 4; i++) add_entry(OP_CPU_RD, {8'hFF, rand_byte()}, 8'h00);
		foreach (DEAD_ADDRS[i]) begin
			add_entry(OP_CPU_WR, DEAD_ADDRS[i], rand_byte());
			add_entry(OP_DL_WR, DEAD_ADDRS[i], rand_byte());
			add_entry(OP_CPU_RD, DEAD_ADDRS[i], 8'h00);
		end
		foreach (stim_q[i]) begin
			case (stim_q[i].op)
				OP_DL_WR:  loader_write(stim_q[i].addr, stim_q[i].data, 1'b0);
				OP_CPU_WR: cpu_access(stim_q[i].addr, stim_q[i].data, 1'b1, got);
				default: begin
					cpu_access(stim_q[i].addr, 8'h00, 1'b0, got);
					check_data($sformatf("cpu_rdata_o[%h]", stim_q[i].addr), got,
						stim_q[i].exp_data);
				end
			endcase
		end

		// tape out follows the aci access parity
		for (int i = 0; i < 6; i++) begin
			d = rand_byte();
			rx = d[0];
			@(posedge sys_clock);
			uart_rx_i <= rx;
			@(posedge sys_clock);  // input latch settles
			if (i % 3 == 2) begin
				cpu_access(ACI_LAST - addr_t'(i), d, 1'b1, got);
			end else begin
				cpu_access(ACI_BASE + addr_t'(i * 16'h50), 8'h00, 1'b0, got);
				check_data("cpu_rdata_o aci", got, {7'b0000000, ~rx});
			end
			check_bit("tape_out_o", tape_out_o, logic'((i + 1) % 2));
		end

		// dac at half scale
		@(posedge sys_clock);
		monitor_tape_in_i <= 1'b1;
		uart_rx_i         <= 1'b0;
		repeat (4) @(posedge sys_clock);
		high = 0;
		high_r = 0;
		repeat (256) begin
			@(negedge sys_clock);
			high += int'(audio_l_o);
			high_r += int'(audio_r_o);
		end
		check_count("audio_l_o high cycles", high, 128);
		check_count("audio_r_o high cycles", high_r, 128);

		$display("summary: %0d check errors, %0d timeouts", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// hard stop if the run hangs
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clock);
		$display("timeout: run exceeded %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: verilog.f
hw/bus_pkg.sv
hw/timing_pkg.sv
hw/mem_bus_if.sv
hw/clock_enable_gen.sv
hw/bus_arbiter.sv
hw/memory_banks.sv
hw/tape_interface.sv
hw/apple1_bus_top.sv
verification/apple1_bus_properties.sv
verification/tb_apple1_bus.sv

// File: Makefile
# Verilator flow for the Apple-1 memory-bus core.
# Any variable can be overridden, e.g. make sim LOG=run2.log

VERILATOR  ?= verilator
TOP        ?= tb_apple1_bus
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_TEXT  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/rom_wozmon.hex
// woz monitor, one byte per column, 16 bytes per line
// first line is ff00, last line is fff0
D8 58 A0 7F 8C 12 D0 A9 A7 8D 11 D0 8D 13 D0 C9
DF F0 13 C9 9B F0 03 C8 10 0F A9 DC 20 EF FF A9
8D 20 EF FF A0 01 88 30 F6 AD 11 D0 10 FB AD 10
D0 99 00 02 20 EF FF C9 8D D0 D4 A0 FF A9 00 AA
0A 85 2B C8 B9 00 02 C9 8D F0 D4 C9 AE 90 F4 F0
F0 C9 BA F0 EB C9 D2 F0 3B 86 28 86 29 84 2A B9
00 02 49 B0 C9 0A 90 06 69 88 C9 FA 90 11 0A 0A
0A 0A A2 04 0A 26 28 26 29 CA D0 F8 C8 D0 E0 C4
2A F0 97 24 2B 50 10 A5 28 81 26 E6 26 D0 B5 E6
27 4C 44 FF 6C 24 00 30 2B A2 02 B5 27 95 25 95
23 CA D0 F7 D0 14 A9 8D 20 EF FF A5 25 20 DC FF
A5 24 20 DC FF A9 BA 20 EF FF A9 A0 20 EF FF A1
24 20 DC FF 86 2B A5 24 C5 28 A5 25 E5 29 B0 C1
E6 24 D0 02 E6 25 A5 24 29 07 10 C8 48 4A 4A 4A
4A 20 E5 FF 68 29 0F 09 B0 C9 BA 90 02 69 06 2C
12 D0 30 FB 8D 12 D0 60 00 00 00 0F 00 FF 00 00
